// ==== filelist.f ====
+incdir+logic
logic/l1_pkg.sv
logic/sram_dp.sv
logic/l1_lookup_if.sv
logic/l1_tag_stage.sv
logic/l1_lrum.sv
logic/l1_lookup_top.sv
verif/l1_lookup_sva.sv
verif/l1_lookup_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the L1 lookup testbench with Verilator, then search the log for the pass line
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f filelist.f --top-module l1_lookup_tb \
  -o l1_lookup_sim &&
./obj_dir/l1_lookup_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== verif/l1_lookup_tb.sv ====
// Self-checking testbench for the L1 lookup path, runs a directed table then an LFSR random phase
`timescale 1ns/100ps
`include "l1_defs.svh"

module l1_lookup_tb;

  import l1_pkg::*;

  localparam int RST_CYC   = 3;
  localparam int TBL_LEN   = 29;
  localparam int RAND_NUM  = 64;
  localparam int CYC_LIMIT = (RST_CYC + `L1_SET_NUM + TBL_LEN + RAND_NUM) * 2;

  // One directed request and its expected result
  typedef struct packed {
    set_idx_t idx;
    tag_t     tag;
    logic     hit;
    way_vec_t way;
    logic     evict;
  } tbl_row_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req;
  set_idx_t    idx;
  tag_t        tag;
  logic        ready;
  logic        hit;
  logic        evict_val;
  way_vec_t    way_vect;

  tbl_row_t    tbl [TBL_LEN];

  // Reference model of valid, used and tag bits per set
  way_vec_t    m_val  [`L1_SET_NUM];
  way_vec_t    m_used [`L1_SET_NUM];
  tag_t        m_tag  [`L1_SET_NUM][`L1_WAY_NUM];

  // Request now in the analyze stage
  logic        pend;
  set_idx_t    pend_idx;
  tag_t        pend_tag;
  logic        pend_hit;
  way_vec_t    pend_way;
  logic        pend_evict;

  int          test_num;
  int          test_errs;
  int          fail_cnt;
  int          sva_fails;
  int          cycle_cnt = 0;
  logic [31:0] lfsr;

  l1_lookup_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .idx       (idx),
    .tag       (tag),
    .ready     (ready),
    .hit       (hit),
    .evict_val (evict_val),
    .way_vect  (way_vect)
  );

  // Checker on both stages
  bind l1_tag_stage l1_lookup_sva u_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .ready    (ready),
    .req_r    (req_r),
    .way_vect (lk.way_vect)
  );
  bind l1_lrum l1_lookup_sva u_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .ready    (ready),
    .req_r    (lk.req_r),
    .way_vect (lk.way_vect)
  );

  always #5 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYC_LIMIT) begin
      $display("Timeout after %0d cycles, run stopped", cycle_cnt);
      $display("tests failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // Compare tasks and test bookkeeping
  // --------------------------------------------------

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_way(input string name, input way_vec_t got, input way_vec_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic report_test(input string label);
    test_num++;
    if (test_errs == 0) begin
      $display("test %0d %s: ok", test_num, label);
    end else begin
      fail_cnt++;
      $display("test %0d %s: FAIL", test_num, label);
    end
  endtask

  // --------------------------------------------------
  // Reference model and random source
  // --------------------------------------------------

  // Sequential lookup on the model with state updated by the replacement rules
  task automatic model_access(input set_idx_t s, input tag_t t, output logic exp_hit,
                              output way_vec_t exp_way, output logic exp_evict);
    way_vec_t nxt;
    int       first_free;
    exp_hit    = 1'b0;
    exp_way    = '0;
    first_free = -1;
    for (int w = 0; w < `L1_WAY_NUM; w++) begin
      if (m_val[s][w] && m_tag[s][w] == t) begin
        exp_hit    = 1'b1;
        exp_way[w] = 1'b1;
      end
      // Lowest way whose used bit is clear
      if (!m_used[s][w] && first_free < 0) begin
        first_free = w;
      end
    end
    exp_evict = !exp_hit && (m_val[s] == '1);
    if (!exp_hit) begin
      exp_way               = way_vec_t'(1) << first_free;
      m_tag[s][first_free]  = t;
      m_val[s]              = m_val[s] | exp_way;
    end
    // Saturated used bits restart from the chosen way
    nxt       = m_used[s] | exp_way;
    m_used[s] = (nxt == '1) ? exp_way : nxt;
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  // --------------------------------------------------
  // Pipelined driver
  // --------------------------------------------------

  // Check the request in analyze on the falling edge and then drive the next one
  task automatic step(input logic do_req, input set_idx_t s, input tag_t t,
                      input logic exp_hit, input way_vec_t exp_way, input logic exp_evict);
    @(negedge clk);
    if (pend) begin
      test_errs = 0;
      check_flag("hit", hit, pend_hit);
      check_way("way_vect", way_vect, pend_way);
      check_flag("evict_val", evict_val, pend_evict);
      report_test($sformatf("idx 0x%h tag 0x%h", pend_idx, pend_tag));
    end
    req        = do_req;
    idx        = s;
    tag        = t;
    pend       = do_req;
    pend_idx   = s;
    pend_tag   = t;
    pend_hit   = exp_hit;
    pend_way   = exp_way;
    pend_evict = exp_evict;
  endtask

  initial begin
    logic        e_hit;
    way_vec_t    e_way;
    logic        e_evict;
    logic [31:0] bits;
    set_idx_t    r_idx;
    tag_t        r_tag;
    int          wait_cyc;
    rst_n     = 1'b0;
    req       = 1'b0;
    idx       = '0;
    tag       = '0;
    pend      = 1'b0;
    test_num  = 0;
    fail_cnt  = 0;
    lfsr      = 32'h31f6a5f3;
    for (int s = 0; s < `L1_SET_NUM; s++) begin
      m_val[s]  = '0;
      m_used[s] = '0;
      for (int w = 0; w < `L1_WAY_NUM; w++) begin
        m_tag[s][w] = '0;
      end
    end

    // First touch of every set misses into way 0
    for (int i = 0; i < `L1_SET_NUM; i++) begin
      tbl[i] = '{set_idx_t'(i), tag_t'(8'h10 + i), 1'b0, 4'b0001, 1'b0};
    end
    // Fill then hit
    tbl[16] = '{4'd3, 8'h13, 1'b1, 4'b0001, 1'b0};
    // Set 5 replacement order with saturation at rows 19 and 23
    tbl[17] = '{4'd5, 8'hA1, 1'b0, 4'b0010, 1'b0};
    tbl[18] = '{4'd5, 8'hA2, 1'b0, 4'b0100, 1'b0};
    tbl[19] = '{4'd5, 8'hA3, 1'b0, 4'b1000, 1'b0};
    tbl[20] = '{4'd5, 8'hA4, 1'b0, 4'b0001, 1'b1};
    tbl[21] = '{4'd5, 8'hA4, 1'b1, 4'b0001, 1'b0};
    tbl[22] = '{4'd5, 8'hA1, 1'b1, 4'b0010, 1'b0};
    tbl[23] = '{4'd5, 8'hA5, 1'b0, 4'b0100, 1'b1};
    tbl[24] = '{4'd5, 8'hA5, 1'b1, 4'b0100, 1'b0};
    tbl[25] = '{4'd5, 8'hA2, 1'b0, 4'b0001, 1'b1};
    // Miss then same tag next cycle through the bypass
    tbl[26] = '{4'd9, 8'h99, 1'b0, 4'b0010, 1'b0};
    tbl[27] = '{4'd9, 8'h99, 1'b1, 4'b0010, 1'b0};
    tbl[28] = '{4'd9, 8'h19, 1'b1, 4'b0001, 1'b0};

    // Outputs stay quiet in reset
    test_errs = 0;
    for (int c = 0; c < RST_CYC; c++) begin
      @(negedge clk);
      check_flag("ready", ready, 1'b0);
      check_flag("hit", hit, 1'b0);
      check_flag("evict_val", evict_val, 1'b0);
    end
    rst_n    = 1'b1;
    wait_cyc = 0;
    while (ready !== 1'b1 && wait_cyc < `L1_SET_NUM + 2) begin
      @(negedge clk);
      wait_cyc++;
    end
    if (ready !== 1'b1) begin
      $display("Ready did not rise within %0d cycles after reset", `L1_SET_NUM + 2);
      test_errs++;
    end else if (wait_cyc < `L1_SET_NUM) begin
      $display("Ready rose after %0d cycles, before the clean walked every set", wait_cyc);
      test_errs++;
    end
    report_test("reset clean");

    // --------------------------------------------------
    // Directed table applied back to back
    // --------------------------------------------------
    foreach (tbl[r]) begin
      model_access(tbl[r].idx, tbl[r].tag, e_hit, e_way, e_evict);
      if (e_hit !== tbl[r].hit || e_way !== tbl[r].way || e_evict !== tbl[r].evict) begin
        $display("Table row %0d does not agree with the reference model", r);
        fail_cnt++;
      end
      step(1'b1, tbl[r].idx, tbl[r].tag, tbl[r].hit, tbl[r].way, tbl[r].evict);
    end

    // --------------------------------------------------
    // Random phase on sets 12 to 15 with eight tags each
    // --------------------------------------------------
    for (int n = 0; n < RAND_NUM; n++) begin
      draw_bits(2, bits);
      // Occasional idle cycle between requests
      if (&bits[1:0]) begin
        step(1'b0, '0, '0, 1'b0, '0, 1'b0);
      end
      draw_bits(2, bits);
      r_idx = set_idx_t'({2'b11, bits[1:0]});
      draw_bits(3, bits);
      r_tag = tag_t'({5'b11000, bits[2:0]});
      model_access(r_idx, r_tag, e_hit, e_way, e_evict);
      step(1'b1, r_idx, r_tag, e_hit, e_way, e_evict);
    end
    // Collect the last result
    step(1'b0, '0, '0, 1'b0, '0, 1'b0);

    sva_fails = DUT.u_lrum.u_sva.assert_fails + DUT.u_tag_stage.u_sva.assert_fails;
    $display("Summary: %0d tests run, %0d failing, %0d assertion failures",
             test_num, fail_cnt, sva_fails);
    if (fail_cnt == 0 && sva_fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== verif/l1_lookup_sva.sv ====
// Assertion checker bound into both lookup stages, checks way select shape and ready behavior
`timescale 1ns/100ps

module l1_lookup_sva (
  input logic             clk,
  input logic             rst_n,
  input logic             ready,
  input logic             req_r,
  input l1_pkg::way_vec_t way_vect
);

  // Failures seen by this checker
  int assert_fails = 0;

  // --------------------------------------------------
  // Way select
  // --------------------------------------------------

  // Exactly one hit or allocation way
  a_way_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    req_r |-> $onehot(way_vect))
    else begin
      assert_fails++;
      $error("way_vect not one-hot during a lookup: 0x%h", way_vect);
    end

  // --------------------------------------------------
  // Ready
  // --------------------------------------------------

  // Clean runs once so ready holds afterwards
  a_ready_holds: assert property (@(posedge clk) disable iff (!rst_n)
    ready |=> ready)
    else begin
      assert_fails++;
      $error("ready fell after it had risen");
    end

endmodule

// ==== logic/l1_lookup_top.sv ====
// Top level of the L1 lookup path, joins tag stage and replacement manager over the lookup bundle
`timescale 1ns/100ps

module l1_lookup_top (
  input  logic               clk,
  input  logic               rst_n,

  // Request, one-cycle strobe
  input  logic               req,
  input  l1_pkg::set_idx_t   idx,
  input  l1_pkg::tag_t       tag,

  // Status and result, one cycle after req
  output logic               ready,
  output logic               hit,
  output logic               evict_val,
  output l1_pkg::way_vec_t   way_vect
);

  logic tag_ready;
  logic lru_ready;

  // Analyze-stage bundle
  l1_lookup_if lk ();

  // Tag and valid path
  l1_tag_stage u_tag_stage (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .idx   (idx),
    .tag   (tag),
    .ready (tag_ready),
    .lk    (lk.tag_side)
  );

  // Hit, way choice and used bits
  l1_lrum u_lrum (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .idx       (idx),
    .ready     (lru_ready),
    .hit       (hit),
    .evict_val (evict_val),
    .lk        (lk.lru_side)
  );

  // Both cleans run the same count
  assign ready    = tag_ready & lru_ready;
  assign way_vect = lk.way_vect;

endmodule

// ==== logic/l1_lrum.sv ====
// Replacement manager with used-bit array, hardware clean, same-set bypass and eviction flag
`timescale 1ns/100ps
`include "l1_defs.svh"

module l1_lrum (
  input  logic             clk,
  input  logic             rst_n,

  // Read stage
  input  logic             req,
  input  l1_pkg::set_idx_t idx,
  output logic             ready,

  // Analyze stage
  output logic             hit,
  output logic             evict_val,
  l1_lookup_if.lru_side    lk
);

  import l1_pkg::*;

  localparam set_idx_t CLEAN_LAST = set_idx_t'(`L1_SET_NUM - 1);

  clean_state_e clean_state;
  set_idx_t     clean_addr;
  logic         clean_run;

  logic         wen;
  set_idx_t     waddr;
  way_vec_t     wdata;

  logic         bypass_r;
  way_vec_t     used_bypass_r;
  way_vec_t     used_sram;
  way_vec_t     used_cur;
  way_vec_t     used_upd;
  way_vec_t     used_next;

  way_vec_t     hit_vect;
  way_vec_t     alloc_vect;
  way_vec_t     way_sel;

  // --------------------------------------------------
  // Lowest set bit, zero in gives zero out
  // --------------------------------------------------
  function automatic way_vec_t lowest_one(input way_vec_t vec);
    way_vec_t res;
    logic     found;
    res   = '0;
    found = 1'b0;
    for (int i = 0; i < `L1_WAY_NUM; i++) begin
      if (vec[i] && !found) begin
        res[i] = 1'b1;
        found  = 1'b1;
      end
    end
    return res;
  endfunction

  // --------------------------------------------------
  // Hardware clean
  // --------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clean_state <= CLEAN_RUN;
      clean_addr  <= '0;
    end else if (clean_state == CLEAN_RUN) begin
      clean_addr <= clean_addr + set_idx_t'(1);
      // Last set written this edge
      if (clean_addr == CLEAN_LAST) begin
        clean_state <= CLEAN_DONE;
      end
    end
  end

  assign clean_run = (clean_state == CLEAN_RUN);
  assign ready     = ~clean_run;

  // Clean owns the write port until done
  assign wen   = clean_run | lk.req_r;
  assign waddr = clean_run ? clean_addr : lk.idx_r;
  assign wdata = clean_run ? '0 : used_next;

  // --------------------------------------------------
  // Read stage
  // --------------------------------------------------

  // Same set as the request now in analyze
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bypass_r <= 1'b0;
    end else begin
      bypass_r <= req & lk.req_r & (idx == lk.idx_r);
    end
  end

  // --------------------------------------------------
  // Analyze stage
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (lk.req_r) begin
      used_bypass_r <= used_next;
    end
  end

  assign used_cur = bypass_r ? used_bypass_r : used_sram;

  // Hit needs a valid way with matching tag
  assign hit_vect = lk.ld_val_vect & lk.tag_cmp_vect;
  assign hit      = lk.req_r & |hit_vect;

  // Allocate at the lowest way not recently used
  assign alloc_vect = lowest_one(~used_cur);
  assign way_sel    = hit ? hit_vect : alloc_vect;

  // Miss into a full set drops a valid line
  assign evict_val = lk.req_r & ~hit & (&lk.ld_val_vect);

  // Saturate, then restart from the chosen way
  assign used_upd  = used_cur | way_sel;
  assign used_next = (&used_upd) ? way_sel : used_upd;

  assign lk.way_vect = way_sel;

  // Used-bit array
  sram_dp #(
    .WIDTH (`L1_WAY_NUM),
    .DEPTH (`L1_SET_NUM)
  ) u_used_mem (
    .clk   (clk),
    .wen   (wen),
    .waddr (waddr),
    .wdata (wdata),
    .ren   (req),
    .raddr (idx),
    .rdata (used_sram)
  );

endmodule

// ==== logic/l1_tag_stage.sv ====
// Tag and valid arrays with hardware clean, same-set bypass, tag compare and fill on miss
`timescale 1ns/100ps
`include "l1_defs.svh"

module l1_tag_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req,
  input  l1_pkg::set_idx_t idx,
  input  l1_pkg::tag_t     tag,
  output logic             ready,
  l1_lookup_if.tag_side    lk
);

  import l1_pkg::*;

  localparam set_idx_t CLEAN_LAST = set_idx_t'(`L1_SET_NUM - 1);

  clean_state_e clean_state;
  set_idx_t     clean_addr;
  logic         clean_run;

  logic         req_r;
  set_idx_t     idx_r;
  tag_t         tag_r;
  logic         bypass_r;

  way_vec_t     val_sram;
  way_vec_t     val_bypass_r;
  way_vec_t     val_cur;
  way_vec_t     val_next;
  tag_t         tag_sram     [`L1_WAY_NUM];
  tag_t         tag_bypass_r [`L1_WAY_NUM];
  tag_t         tag_cur      [`L1_WAY_NUM];
  logic         fill;

  // --------------------------------------------------
  // Hardware clean
  // --------------------------------------------------

  // One set per cycle, valid bits only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clean_state <= CLEAN_RUN;
      clean_addr  <= '0;
    end else if (clean_state == CLEAN_RUN) begin
      clean_addr <= clean_addr + set_idx_t'(1);
      if (clean_addr == CLEAN_LAST) begin
        clean_state <= CLEAN_DONE;
      end
    end
  end

  assign clean_run = (clean_state == CLEAN_RUN);
  assign ready     = ~clean_run;

  // --------------------------------------------------
  // Read stage
  // --------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_r    <= 1'b0;
      bypass_r <= 1'b0;
    end else begin
      req_r    <= req;
      // Older request to this set writes back on the same edge
      bypass_r <= req & req_r & (idx == idx_r);
    end
  end

  // Request payload
  always_ff @(posedge clk) begin
    idx_r <= idx;
    tag_r <= tag;
  end

  // --------------------------------------------------
  // Analyze stage
  // --------------------------------------------------

  assign val_cur = bypass_r ? val_bypass_r : val_sram;

  // Miss when no valid way compares equal, way comes from the manager
  assign fill     = req_r & ~|(lk.tag_cmp_vect & val_cur);
  assign val_next = val_cur | (fill ? lk.way_vect : '0);

  // Latest set contents for the next same-set request
  always_ff @(posedge clk) begin
    if (req_r) begin
      val_bypass_r <= val_next;
    end
  end

  // Valid array, zeros during clean
  sram_dp #(
    .WIDTH (`L1_WAY_NUM),
    .DEPTH (`L1_SET_NUM)
  ) u_val_mem (
    .clk   (clk),
    .wen   (clean_run | fill),
    .waddr (clean_run ? clean_addr : idx_r),
    .wdata (clean_run ? '0 : val_next),
    .ren   (req),
    .raddr (idx),
    .rdata (val_sram)
  );

  // Per-way tag array, bypass and compare
  for (genvar w = 0; w < `L1_WAY_NUM; w++) begin : g_way
    sram_dp #(
      .WIDTH (`L1_TAG_WIDTH),
      .DEPTH (`L1_SET_NUM)
    ) u_tag_mem (
      .clk   (clk),
      .wen   (fill & lk.way_vect[w]),
      .waddr (idx_r),
      .wdata (tag_r),
      .ren   (req),
      .raddr (idx),
      .rdata (tag_sram[w])
    );

    assign tag_cur[w] = bypass_r ? tag_bypass_r[w] : tag_sram[w];

    always_ff @(posedge clk) begin
      if (req_r) begin
        tag_bypass_r[w] <= (fill & lk.way_vect[w]) ? tag_r : tag_cur[w];
      end
    end

    // Raw compare, valid masking is done downstream
    assign lk.tag_cmp_vect[w] = (tag_cur[w] == tag_r);
  end

  assign lk.req_r       = req_r;
  assign lk.idx_r       = idx_r;
  assign lk.ld_val_vect = val_cur;

endmodule

// ==== logic/l1_lookup_if.sv ====
// Analyze-stage bundle between the tag stage and the replacement manager, with one modport per side
`timescale 1ns/100ps

interface l1_lookup_if;

  import l1_pkg::*;

  // Request in the analyze stage
  logic     req_r;
  set_idx_t idx_r;

  // Per-way valid bits and raw tag compare
  way_vec_t ld_val_vect;
  way_vec_t tag_cmp_vect;

  // Hit way or allocation way, back from the replacement manager
  way_vec_t way_vect;

  // Tag side owns request and per-way status
  modport tag_side (
    output req_r,
    output idx_r,
    output ld_val_vect,
    output tag_cmp_vect,
    input  way_vect
  );

  // Replacement side answers with the way
  modport lru_side (
    input  req_r,
    input  idx_r,
    input  ld_val_vect,
    input  tag_cmp_vect,
    output way_vect
  );

endinterface

// ==== logic/sram_dp.sv ====
// Simple two-port RAM, one write port and one registered read port, sized by WIDTH and DEPTH
`timescale 1ns/100ps

module sram_dp #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic             clk,

  // Write port
  input  logic             wen,
  input  l1_pkg::set_idx_t waddr,
  input  logic [WIDTH-1:0] wdata,

  // Read port
  input  logic             ren,
  input  l1_pkg::set_idx_t raddr,
  output logic [WIDTH-1:0] rdata
);

  // Storage array, no reset
  logic [WIDTH-1:0] mem [DEPTH];

  // --------------------------------------------------
  // Write and read
  // --------------------------------------------------

  // Write on wen
  always_ff @(posedge clk) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read, holds last data while ren low
  // Same-edge write to the same address returns old contents
  always_ff @(posedge clk) begin
    if (ren) begin
      rdata <= mem[raddr];
    end
  end

endmodule

// ==== logic/l1_pkg.sv ====
// Shared vector types and the clean FSM enum for the L1 lookup path, import where used
`include "l1_defs.svh"

package l1_pkg;

  // --------------------------------------------------
  // Vector types
  // --------------------------------------------------

  // One bit per way: select, valid, compare or used
  typedef logic [`L1_WAY_NUM-1:0] way_vec_t;

  // Set index
  typedef logic [`CORE_IDX_WIDTH-1:0] set_idx_t;

  // Address tag
  typedef logic [`L1_TAG_WIDTH-1:0] tag_t;

  // --------------------------------------------------
  // Hardware clean
  // --------------------------------------------------

  // Walking the arrays after reset, then done for good
  typedef enum logic {
    CLEAN_RUN,
    CLEAN_DONE
  } clean_state_e;

endpackage

// ==== logic/l1_defs.svh ====
// Cache geometry macros shared by the package and the lookup RTL, include where sizes are needed
`ifndef L1_DEFS_SVH
`define L1_DEFS_SVH

// --------------------------------------------------
// Cache geometry
// --------------------------------------------------

// Ways per set
`define L1_WAY_NUM 4

// Sets in the cache
`define L1_SET_NUM 16

// Set index width, log2 of the set count
`define CORE_IDX_WIDTH 4

// --------------------------------------------------
// Address split
// --------------------------------------------------

// Tag bits kept per way
`define L1_TAG_WIDTH 8

`endif
